//--- sim.f
hdl/sd_cmd_pkg.sv
hdl/sd_rsp_pkg.sv
hdl/sd_cmd_ifs.sv
hdl/sd_cmd_write.sv
hdl/sd_rsp_read.sv
hdl/sd_rsp_regs.sv
hdl/sd_cmd_seq.sv
hdl/sd_cmd_top.sv
testbench/sd_card_model.sv
testbench/tb_sd_cmd_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the command path testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_sd_cmd_top -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned $status"
  exit $status
fi

./obj_dir/Vtb_sd_cmd_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation run returned $status"
  exit $status
fi

exit 0

//--- testbench/tb_sd_cmd_top.sv
`timescale 1ns/1ps

module tb_sd_cmd_top;
  import sd_cmd_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 64;
  localparam int unsigned NRC_CYCLES     = 8;
  localparam int          WAIT_LIMIT     = 1000; // cycles per command
  localparam int          NUM_TESTS      = 13;

  // card actions, same codes as in the card model
  localparam logic [2:0] ACT_REPLY   = 3'd0;
  localparam logic [2:0] ACT_SILENT  = 3'd1;
  localparam logic [2:0] ACT_BAD_CRC = 3'd2;
  localparam logic [2:0] ACT_BAD_IDX = 3'd3;
  localparam logic [2:0] ACT_BAD_END = 3'd4;

  typedef struct packed {
    logic [5:0]   index;
    logic [31:0]  arg;
    rsp_type_e    rtype;
    logic         crc_en;
    logic         idx_en;
    logic [2:0]   action;
    logic [7:0]   busy_len;
    logic [119:0] payload;
  } entry_t;

  // index, argument, type, crc check, index check, card action, busy cycles, payload
  entry_t tests [NUM_TESTS] = '{
    '{6'd0,  32'h0000_0000, RSP_NONE,       1'b0, 1'b0, ACT_REPLY,   8'd0,  120'h0},
    '{6'd8,  32'h0000_01aa, RSP_SHORT,      1'b1, 1'b1, ACT_REPLY,   8'd0,  120'h1aa},
    '{6'd2,  32'h0000_0000, RSP_LONG,       1'b1, 1'b0, ACT_REPLY,   8'd0,
      120'h11_2233_4455_6677_8899_aabb_ccdd_eeff},
    '{6'd7,  32'h1234_0000, RSP_SHORT_BUSY, 1'b1, 1'b1, ACT_REPLY,   8'd12, 120'h0700},
    '{6'd13, 32'h1234_0000, RSP_SHORT,      1'b1, 1'b1, ACT_SILENT,  8'd0,  120'h0},
    '{6'd0,  32'h0000_0000, RSP_NONE,       1'b1, 1'b1, ACT_SILENT,  8'd0,  120'h0},
    '{6'd17, 32'h0000_0200, RSP_SHORT,      1'b1, 1'b1, ACT_BAD_CRC, 8'd0,  120'h0900},
    '{6'd16, 32'h0000_0200, RSP_SHORT,      1'b0, 1'b1, ACT_BAD_CRC, 8'd0,  120'h0920},
    '{6'd55, 32'h1234_0000, RSP_SHORT,      1'b1, 1'b1, ACT_BAD_IDX, 8'd0,  120'h0120},
    '{6'd9,  32'h1234_0000, RSP_SHORT,      1'b1, 1'b0, ACT_BAD_IDX, 8'd0,  120'h0b00},
    '{6'd3,  32'h0000_0000, RSP_SHORT,      1'b1, 1'b1, ACT_BAD_END, 8'd0,  120'h1234_0500},
    '{6'd38, 32'h0000_0000, RSP_SHORT_BUSY, 1'b1, 1'b1, ACT_REPLY,   8'd5,  120'h0800},
    '{6'd10, 32'h1234_0000, RSP_LONG,       1'b1, 1'b1, ACT_BAD_CRC, 8'd0,
      120'hfe_dcba_9876_5432_10f0_e1d2_c3b4_a596}
  };

  logic         clk;
  logic         rst_n;
  logic         cmd_start;
  logic [5:0]   cmd_index;
  logic [31:0]  cmd_arg;
  rsp_type_e    rsp_type;
  logic         crc_check_en;
  logic         index_check_en;
  logic         busy_dat0;
  logic         sd_cmd_in;
  logic         sd_cmd_out;
  logic         sd_cmd_en;
  logic         cmd_inhibit;
  logic         cmd_done;
  logic         rsp_done;
  logic         rsp_update;
  logic [31:0]  response0;
  logic [31:0]  response1;
  logic [31:0]  response2;
  logic [31:0]  response3;
  logic         err_timeout;
  logic         err_crc;
  logic         err_end_bit;
  logic         err_index;
  logic [2:0]   card_action;
  logic [7:0]   card_busy_len;
  logic [119:0] card_payload;
  logic [47:0]  card_frame;
  logic         card_crc_ok;
  int           card_frames;

  sd_cmd_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .NRC_CYCLES     (NRC_CYCLES)
  ) uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cmd_start_i      (cmd_start),
    .cmd_index_i      (cmd_index),
    .cmd_arg_i        (cmd_arg),
    .rsp_type_i       (rsp_type),
    .crc_check_en_i   (crc_check_en),
    .index_check_en_i (index_check_en),
    .busy_dat0_i      (busy_dat0),
    .sd_cmd_i         (sd_cmd_in),
    .sd_cmd_o         (sd_cmd_out),
    .sd_cmd_en_o      (sd_cmd_en),
    .cmd_inhibit_o    (cmd_inhibit),
    .cmd_done_o       (cmd_done),
    .rsp_done_o       (rsp_done),
    .response0_o      (response0),
    .response1_o      (response1),
    .response2_o      (response2),
    .response3_o      (response3),
    .rsp_update_o     (rsp_update),
    .err_timeout_o    (err_timeout),
    .err_crc_o        (err_crc),
    .err_end_bit_o    (err_end_bit),
    .err_index_o      (err_index)
  );

  sd_card_model card (
    .clk_i          (clk),
    .cmd_i          (sd_cmd_out),
    .cmd_en_i       (sd_cmd_en),
    .rsp_type_i     (rsp_type),
    .action_i       (card_action),
    .busy_len_i     (card_busy_len),
    .payload_i      (card_payload),
    .cmd_o          (sd_cmd_in),
    .busy_o         (busy_dat0),
    .frame_o        (card_frame),
    .frame_crc_ok_o (card_crc_ok),
    .frame_cnt_o    (card_frames)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at t=%0t while waiting for %s", $time, what);
    $display("sim failed");
    $fatal(1, "wait limit reached");
  endtask

  task automatic run_entry(input int n);
    entry_t      e;
    logic [31:0] old_rsp [4];
    logic [31:0] exp_rsp [4];
    logic        replied;
    int          cycles;
    int          done_at;
    int          update_at;
    int          n_done;
    int          n_cmd_done;
    int          n_update;
    int          n_tmo;
    int          n_crc;
    int          n_end;
    int          n_idx;
    int          frames_before;
    e             = tests[n];
    replied       = (e.rtype != RSP_NONE) && (e.action != ACT_SILENT);
    old_rsp[0]    = response0;
    old_rsp[1]    = response1;
    old_rsp[2]    = response2;
    old_rsp[3]    = response3;
    frames_before = card_frames;
    cycles        = 0;
    done_at       = -1;
    update_at     = -1;
    n_done        = 0;
    n_cmd_done    = 0;
    n_update      = 0;
    n_tmo         = 0;
    n_crc         = 0;
    n_end         = 0;
    n_idx         = 0;

    cmd_index      = e.index;
    cmd_arg        = e.arg;
    rsp_type       = e.rtype;
    crc_check_en   = e.crc_en;
    index_check_en = e.idx_en;
    card_action    = e.action;
    card_busy_len  = e.busy_len;
    card_payload   = e.payload;
    cmd_start      = 1'b1;
    @(negedge clk);
    cmd_start = 1'b0;
    check_value("cmd_inhibit_o", cmd_inhibit, 1);

    // inhibit must hold until the turnaround after the response is over
    while (cmd_inhibit) begin
      if (rsp_done) begin
        n_done++;
        done_at = cycles;
      end
      if (rsp_update) begin
        n_update++;
        update_at = cycles;
      end
      n_cmd_done += cmd_done;
      n_tmo      += err_timeout;
      n_crc      += err_crc;
      n_end      += err_end_bit;
      n_idx      += err_index;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("cmd_inhibit_o to fall");
      @(negedge clk);
    end

    check_value("cmd frame count", card_frames, frames_before + 1);
    check_value("cmd frame start bits", card_frame[47:46], 2'b01);
    check_value("cmd frame index", card_frame[45:40], e.index);
    check_value("cmd frame argument", card_frame[39:8], e.arg);
    check_value("cmd frame crc7 ok", card_crc_ok, 1);
    check_value("cmd frame end bit", card_frame[0], 1);

    check_value("rsp_done_o pulses", n_done, 1);
    check_value("cycles rsp_done_o to inhibit low", cycles - done_at, NRC_CYCLES);
    check_value("cmd_done_o pulses", n_cmd_done, e.rtype != RSP_NONE);
    check_value("rsp_update_o pulses", n_update, replied);
    check_value("err_timeout_o pulses", n_tmo,
                (e.rtype != RSP_NONE) && (e.action == ACT_SILENT));
    check_value("err_crc_o pulses", n_crc, replied && e.action == ACT_BAD_CRC && e.crc_en);
    check_value("err_end_bit_o pulses", n_end, replied && e.action == ACT_BAD_END);
    check_value("err_index_o pulses", n_idx,
                replied && e.action == ACT_BAD_IDX && e.idx_en && e.rtype != RSP_LONG);
    if (replied) begin
      // busy keeps the sequencer waiting for as long as dat0 is held
      check_value("cycles rsp_update_o to rsp_done_o", done_at - update_at,
                  (e.rtype == RSP_SHORT_BUSY) ? 1 + e.busy_len : 1);
    end

    exp_rsp = old_rsp;
    if (replied) begin
      exp_rsp[0] = e.payload[31:0];
      if (e.rtype == RSP_LONG) begin
        exp_rsp[1] = e.payload[63:32];
        exp_rsp[2] = e.payload[95:64];
        exp_rsp[3] = {old_rsp[3][31:24], e.payload[119:96]};
      end
    end
    check_value("response0_o", response0, exp_rsp[0]);
    check_value("response1_o", response1, exp_rsp[1]);
    check_value("response2_o", response2, exp_rsp[2]);
    check_value("response3_o", response3, exp_rsp[3]);
  endtask

  initial begin
    rst_n          = 1'b0;
    cmd_start      = 1'b0;
    cmd_index      = '0;
    cmd_arg        = '0;
    rsp_type       = RSP_NONE;
    crc_check_en   = 1'b0;
    index_check_en = 1'b0;
    card_action    = ACT_REPLY;
    card_busy_len  = '0;
    card_payload   = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- testbench/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
  input  logic                  clk_i,
  input  logic                  cmd_i,      // host side of the cmd line
  input  logic                  cmd_en_i,
  input  sd_cmd_pkg::rsp_type_e rsp_type_i,
  input  logic [2:0]            action_i,
  input  logic [7:0]            busy_len_i,
  input  logic [119:0]          payload_i,
  output logic                  cmd_o,      // card side of the cmd line
  output logic                  busy_o,     // dat0 busy, high while busy
  output logic [47:0]           frame_o,    // last command frame received
  output logic                  frame_crc_ok_o,
  output int                    frame_cnt_o
);
  import sd_cmd_pkg::*;

  localparam logic [2:0] ACT_SILENT  = 3'd1;
  localparam logic [2:0] ACT_BAD_CRC = 3'd2;
  localparam logic [2:0] ACT_BAD_IDX = 3'd3;
  localparam logic [2:0] ACT_BAD_END = 3'd4;

  // crc7 over the n low bits of data, msb first
  function automatic logic [6:0] crc7_of(input logic [119:0] data, input int n);
    logic [6:0] c;
    logic       fb;
    int         i;
    c = '0;
    for (i = n - 1; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  task automatic send_response(input logic [5:0] idx);
    logic [135:0] bits;
    logic [5:0]   idx_rsp;
    logic [6:0]   crc;
    logic         end_bit;
    int           len;
    int           i;
    idx_rsp = (action_i == ACT_BAD_IDX) ? (idx ^ 6'h01) : idx;
    end_bit = (action_i != ACT_BAD_END);
    if (rsp_type_i == RSP_LONG) begin
      crc = crc7_of(payload_i, 120); // payload only
      len = 136;
    end else begin
      crc = crc7_of({80'd0, 2'b00, idx_rsp, payload_i[31:0]}, 40);
      len = 48;
    end
    if (action_i == ACT_BAD_CRC) begin
      crc = crc ^ 7'h01;
    end
    if (rsp_type_i == RSP_LONG) begin
      bits = {8'h3f, payload_i, crc, end_bit}; // start, transmission, reserved ones
    end else begin
      bits = {88'd0, 2'b00, idx_rsp, payload_i[31:0], crc, end_bit};
    end
    repeat (3) @(negedge clk_i); // gap after the command end bit
    for (i = len - 1; i >= 0; i--) begin
      cmd_o = bits[i];
      @(negedge clk_i);
    end
    cmd_o = 1'b1;
    if (rsp_type_i == RSP_SHORT_BUSY && busy_len_i != 0) begin
      busy_o = 1'b1;
      repeat (busy_len_i) @(negedge clk_i);
      busy_o = 1'b0;
    end
  endtask

  initial begin
    int          nbits;
    logic [47:0] shreg;
    nbits          = 0;
    shreg          = '0;
    cmd_o          = 1'b1; // pulled up
    busy_o         = 1'b0;
    frame_o        = '0;
    frame_crc_ok_o = 1'b0;
    frame_cnt_o    = 0;
    forever begin
      @(negedge clk_i);
      if (cmd_en_i) begin
        shreg = {shreg[46:0], cmd_i};
        nbits++;
        if (nbits == 48) begin
          nbits          = 0;
          frame_o        = shreg;
          frame_crc_ok_o = (crc7_of({80'd0, shreg[47:8]}, 40) == shreg[7:1]);
          frame_cnt_o++;
          if (rsp_type_i != RSP_NONE && action_i != ACT_SILENT) begin
            send_response(shreg[45:40]); // answer with the index that was sent
          end
        end
      end
    end
  end

endmodule

//--- hdl/sd_cmd_top.sv
`timescale 1ns/1ps

module sd_cmd_top #(
  parameter int unsigned TIMEOUT_CYCLES = 64,
  parameter int unsigned NRC_CYCLES     = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_start_i,
  input  logic [5:0]            cmd_index_i,
  input  logic [31:0]           cmd_arg_i,
  input  sd_cmd_pkg::rsp_type_e rsp_type_i,
  input  logic                  crc_check_en_i,
  input  logic                  index_check_en_i,
  input  logic                  busy_dat0_i,
  input  logic                  sd_cmd_i,
  output logic                  sd_cmd_o,
  output logic                  sd_cmd_en_o,
  output logic                  cmd_inhibit_o,
  output logic                  cmd_done_o,
  output logic                  rsp_done_o,
  output logic [31:0]           response0_o,
  output logic [31:0]           response1_o,
  output logic [31:0]           response2_o,
  output logic [31:0]           response3_o,
  output logic                  rsp_update_o,
  output logic                  err_timeout_o,
  output logic                  err_crc_o,
  output logic                  err_end_bit_o,
  output logic                  err_index_o
);
  import sd_rsp_pkg::*;

  sd_cmd_err_t err;

  sd_tx_if tx_if ();
  sd_rx_if rx_if ();

  sd_cmd_seq #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .NRC_CYCLES     (NRC_CYCLES)
  ) i_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_start_i      (cmd_start_i),
    .cmd_index_i      (cmd_index_i),
    .cmd_arg_i        (cmd_arg_i),
    .rsp_type_i       (rsp_type_i),
    .crc_check_en_i   (crc_check_en_i),
    .index_check_en_i (index_check_en_i),
    .busy_dat0_i      (busy_dat0_i),
    .tx               (tx_if.seq),
    .rx               (rx_if.seq),
    .cmd_inhibit_o    (cmd_inhibit_o),
    .cmd_done_o       (cmd_done_o),
    .rsp_done_o       (rsp_done_o),
    .err_o            (err)
  );

  sd_cmd_write i_write (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tx          (tx_if.writer),
    .sd_cmd_o    (sd_cmd_o),
    .sd_cmd_en_o (sd_cmd_en_o)
  );

  sd_rsp_read i_read (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .sd_cmd_i (sd_cmd_i),
    .rx       (rx_if.reader)
  );

  sd_rsp_regs i_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_type_i   (rsp_type_i),
    .rsp_valid_i  (rx_if.rsp_valid),
    .payload_i    (rx_if.payload),
    .response0_o  (response0_o),
    .response1_o  (response1_o),
    .response2_o  (response2_o),
    .response3_o  (response3_o),
    .rsp_update_o (rsp_update_o)
  );

  assign err_timeout_o = err.timeout;
  assign err_crc_o     = err.crc;
  assign err_end_bit_o = err.end_bit;
  assign err_index_o   = err.index;

endmodule

//--- hdl/sd_cmd_seq.sv
`timescale 1ns/1ps

module sd_cmd_seq #(
  parameter int unsigned TIMEOUT_CYCLES = 64,
  parameter int unsigned NRC_CYCLES     = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmd_start_i,
  input  logic [5:0]              cmd_index_i,
  input  logic [31:0]             cmd_arg_i,
  input  sd_cmd_pkg::rsp_type_e   rsp_type_i,
  input  logic                    crc_check_en_i,
  input  logic                    index_check_en_i,
  input  logic                    busy_dat0_i,
  sd_tx_if.seq                    tx,
  sd_rx_if.seq                    rx,
  output logic                    cmd_inhibit_o,
  output logic                    cmd_done_o,
  output logic                    rsp_done_o,
  output sd_rsp_pkg::sd_cmd_err_t err_o
);
  import sd_cmd_pkg::*;

  localparam int unsigned CNT_MAX = (TIMEOUT_CYCLES > NRC_CYCLES) ? TIMEOUT_CYCLES : NRC_CYCLES;
  localparam int unsigned CNT_W   = $clog2(CNT_MAX + 1);

  cmd_seq_state_e   state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d; // timeout in READ_RSP, N_RC in RSP_RECEIVED
  logic             req_q, req_d;
  logic             inhibit_q;
  logic [5:0]       req_idx_q;
  logic [31:0]      req_arg_q;
  logic [5:0]       cur_idx_q;   // index of the command on the bus
  logic             timeout;

  assign timeout = (state_q == READ_RSP) && !rx.receiving && !rx.rsp_valid &&
                   (cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY:        if (req_q) state_d = WRITE_CMD;
      WRITE_CMD: begin
        if (tx.tx_done) begin
          state_d = (rsp_type_i == RSP_NONE) ? RSP_RECEIVED : BUS_SWITCH;
        end
      end
      BUS_SWITCH:   state_d = READ_RSP;
      READ_RSP: begin
        if (rx.rsp_valid) begin
          state_d = (rsp_type_i == RSP_SHORT_BUSY) ? WAIT_BUSY : RSP_RECEIVED;
        end else if (timeout) begin
          state_d = RSP_RECEIVED;
        end
      end
      WAIT_BUSY:    if (!busy_dat0_i) state_d = RSP_RECEIVED;
      RSP_RECEIVED: if (cnt_q == CNT_W'(NRC_CYCLES - 1)) state_d = READY;
      default:      state_d = READY;
    endcase
  end

  always_comb begin
    cnt_d = cnt_q;
    if (state_d != state_q) begin
      cnt_d = '0;
    end else if (state_q == READ_RSP && rx.receiving) begin
      cnt_d = '0; // a start bit holds off the timeout
    end else if (state_q == READ_RSP || state_q == RSP_RECEIVED) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // extra starts are dropped while a request is pending
  always_comb begin
    req_d = req_q;
    if (tx.start) req_d = 1'b0;
    if (cmd_start_i && !req_q) req_d = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= READY;
      cnt_q     <= '0;
      req_q     <= 1'b0;
      inhibit_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      req_q     <= req_d;
      inhibit_q <= req_d || (state_d != READY);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_start_i && !req_q) begin
      req_idx_q <= cmd_index_i;
      req_arg_q <= cmd_arg_i;
    end
    if (tx.start) cur_idx_q <= req_idx_q;
  end

  assign tx.start    = (state_q == READY) && req_q;
  assign tx.index    = req_idx_q;
  assign tx.argument = req_arg_q;
  assign rx.listen   = (state_q == READ_RSP);
  assign rx.long_rsp = (rsp_type_i == RSP_LONG);

  assign cmd_inhibit_o = inhibit_q;
  assign cmd_done_o    = (state_q == BUS_SWITCH);
  assign rsp_done_o    = (state_q == RSP_RECEIVED) && (cnt_q == '0); // first cycle only

  always_comb begin
    err_o         = '0;
    err_o.timeout = timeout;
    if (state_q == READ_RSP && rx.rsp_valid) begin
      err_o.end_bit = rx.end_bit_err;
      err_o.crc     = crc_check_en_i && !rx.crc_ok;
      // r2 carries no index
      err_o.index   = index_check_en_i && (rsp_type_i != RSP_LONG) &&
                      (rx.payload[37:32] != cur_idx_q);
    end
  end

  // the writer ends each frame exactly one frame length after the start
  a_done_after_start : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tx.start |-> ##CMD_LEN tx.tx_done
  );

  // the writer finishes only while the sequencer waits for it
  a_done_in_write : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tx.tx_done |-> (state_q == WRITE_CMD)
  );

endmodule

//--- hdl/sd_rsp_regs.sv
`timescale 1ns/1ps

module sd_rsp_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  sd_cmd_pkg::rsp_type_e                  rsp_type_i,
  input  logic                                   rsp_valid_i,
  input  logic [sd_rsp_pkg::RSP_PAYLOAD_W-1:0]   payload_i,
  output logic [31:0]                            response0_o,
  output logic [31:0]                            response1_o,
  output logic [31:0]                            response2_o,
  output logic [31:0]                            response3_o,
  output logic                                   rsp_update_o
);
  import sd_cmd_pkg::*;

  assign rsp_update_o = rsp_valid_i && (rsp_type_i != RSP_NONE);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      response0_o <= '0;
      response1_o <= '0;
      response2_o <= '0;
      response3_o <= '0;
    end else if (rsp_update_o) begin
      response0_o <= payload_i[31:0]; // card status or cid/csd low word
      if (rsp_type_i == RSP_LONG) begin
        response1_o       <= payload_i[63:32];
        response2_o       <= payload_i[95:64];
        response3_o[23:0] <= payload_i[119:96]; // upper byte is kept
      end
    end
  end

endmodule

//--- hdl/sd_rsp_read.sv
`timescale 1ns/1ps

module sd_rsp_read (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    sd_cmd_i,
  sd_rx_if.reader rx
);
  import sd_cmd_pkg::*;
  import sd_rsp_pkg::*;

  localparam logic [7:0] LONG_HDR = 8'd8; // start, transmission, reserved

  logic                     rcv_q;
  logic                     valid_q;
  logic                     end_err_q;
  logic [7:0]               bit_cnt_q;  // frame position of the sampled bit
  logic [6:0]               crc_calc_q;
  logic [6:0]               crc_rx_q;
  logic [RSP_PAYLOAD_W-1:0] payload_q;
  logic [7:0]               last_idx;
  logic [7:0]               crc_first;
  logic                     start_det;
  logic                     crc_covered;

  assign last_idx  = rx.long_rsp ? 8'(RSP_LONG_LEN - 1) : 8'(RSP_SHORT_LEN - 1);
  assign crc_first = last_idx - 8'(CRC7_W);
  assign start_det = !rcv_q && rx.listen && !sd_cmd_i;

  // long responses protect only the payload, short ones the whole header
  assign crc_covered = (bit_cnt_q < crc_first) && (!rx.long_rsp || bit_cnt_q >= LONG_HDR);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rcv_q      <= 1'b0;
      valid_q    <= 1'b0;
      end_err_q  <= 1'b0;
      bit_cnt_q  <= '0;
      crc_calc_q <= '0;
      crc_rx_q   <= '0;
    end else begin
      valid_q <= 1'b0;
      if (start_det) begin
        rcv_q      <= 1'b1;
        bit_cnt_q  <= 8'd1;
        crc_calc_q <= '0; // a zero start bit leaves the crc at zero
      end else if (rcv_q && !rx.listen) begin
        rcv_q <= 1'b0; // sequencer gave up
      end else if (rcv_q) begin
        bit_cnt_q <= bit_cnt_q + 8'd1;
        if (crc_covered) begin
          crc_calc_q <= crc7_step(crc_calc_q, sd_cmd_i);
        end
        if (bit_cnt_q >= crc_first && bit_cnt_q < last_idx) begin
          crc_rx_q <= {crc_rx_q[5:0], sd_cmd_i};
        end
        if (bit_cnt_q == last_idx) begin
          rcv_q     <= 1'b0;
          valid_q   <= 1'b1;
          end_err_q <= !sd_cmd_i; // end bit must be 1
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_det) begin
      payload_q <= '0; // start bit lands in bit 0
    end else if (rcv_q && bit_cnt_q < crc_first) begin
      payload_q <= {payload_q[RSP_PAYLOAD_W-2:0], sd_cmd_i};
    end
  end

  assign rx.receiving   = rcv_q;
  assign rx.rsp_valid   = valid_q;
  assign rx.end_bit_err = end_err_q;
  assign rx.crc_ok      = (crc_calc_q == crc_rx_q);
  assign rx.payload     = payload_q;

  // a result only comes back while the sequencer still listens for it
  a_valid_while_listen : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rx.rsp_valid |-> rx.listen
  );

endmodule

//--- hdl/sd_cmd_write.sv
`timescale 1ns/1ps

module sd_cmd_write (
  input  logic     clk_i,
  input  logic     rst_ni,
  sd_tx_if.writer  tx,
  output logic     sd_cmd_o,
  output logic     sd_cmd_en_o
);
  import sd_cmd_pkg::*;

  // bits after the start bit that come from the request
  localparam int unsigned HDR_W = CMD_LEN - CRC7_W - 2;
  localparam logic [5:0] LAST_BIT  = 6'(CMD_LEN - 1);
  localparam logic [5:0] CRC_FIRST = 6'(CMD_LEN - CRC7_W - 1);

  logic             busy_q;
  logic             cmd_q;
  logic [5:0]       bit_cnt_q;  // frame position of the bit on the line
  logic [6:0]       crc_q;      // accumulates, then shifts out
  logic [HDR_W-1:0] shreg_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      cmd_q     <= 1'b1; // line idles high
      bit_cnt_q <= '0;
      crc_q     <= '0;
    end else if (tx.start) begin
      busy_q    <= 1'b1;
      cmd_q     <= 1'b0; // start bit
      bit_cnt_q <= '0;
      crc_q     <= crc7_step('0, 1'b0);
    end else if (busy_q) begin
      bit_cnt_q <= bit_cnt_q + 6'd1;
      if (bit_cnt_q == LAST_BIT) begin
        busy_q <= 1'b0;
        cmd_q  <= 1'b1;
      end else if (bit_cnt_q < CRC_FIRST - 6'd1) begin
        cmd_q <= shreg_q[HDR_W-1];
        crc_q <= crc7_step(crc_q, shreg_q[HDR_W-1]);
      end else if (bit_cnt_q < LAST_BIT - 6'd1) begin
        // crc is complete once bit 39 is on the line
        cmd_q <= crc_q[6];
        crc_q <= {crc_q[5:0], 1'b0};
      end else begin
        cmd_q <= 1'b1; // end bit
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx.start) begin
      shreg_q <= {1'b1, tx.index, tx.argument}; // transmission bit leads
    end else if (busy_q) begin
      shreg_q <= {shreg_q[HDR_W-2:0], 1'b0};
    end
  end

  assign tx.tx_done  = busy_q && (bit_cnt_q == LAST_BIT);
  assign sd_cmd_o    = cmd_q;
  assign sd_cmd_en_o = busy_q;

  // the driver is off again one frame after it turned on
  a_en_one_frame : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(sd_cmd_en_o) |-> ##CMD_LEN !sd_cmd_en_o
  );

endmodule

//--- hdl/sd_cmd_ifs.sv
`timescale 1ns/1ps

// sequencer to command writer
interface sd_tx_if;
  logic        start;    // one cycle, captures index and argument
  logic [5:0]  index;
  logic [31:0] argument;
  logic        tx_done;  // high with the last frame bit

  modport seq    (output start, index, argument, input tx_done);
  modport writer (input start, index, argument, output tx_done);
endinterface

// sequencer to response reader
interface sd_rx_if;
  import sd_rsp_pkg::*;

  logic                     listen;
  logic                     long_rsp;
  logic                     receiving;
  logic                     rsp_valid;   // results below hold only with this
  logic                     end_bit_err;
  logic                     crc_ok;
  logic [RSP_PAYLOAD_W-1:0] payload;

  modport seq (
    output listen, long_rsp,
    input  receiving, rsp_valid, end_bit_err, crc_ok, payload
  );
  modport reader (
    input  listen, long_rsp,
    output receiving, rsp_valid, end_bit_err, crc_ok, payload
  );
endinterface

//--- hdl/sd_rsp_pkg.sv
package sd_rsp_pkg;

  // response frame lengths on the cmd line
  localparam int unsigned RSP_SHORT_LEN = 48;
  localparam int unsigned RSP_LONG_LEN  = 136;

  // bits kept from a response, bit 0 sits right before the crc
  // long: cid/csd without the 8 header bits
  // short: start, transmission, index and card status
  localparam int unsigned RSP_PAYLOAD_W = 120;

  // single cycle error strobes towards the interrupt status
  typedef struct packed {
    logic timeout;
    logic crc;
    logic end_bit;
    logic index;
  } sd_cmd_err_t;

endpackage

//--- hdl/sd_cmd_pkg.sv
package sd_cmd_pkg;

  // command frame: start, transmission, index, argument, crc7, end
  localparam int unsigned CMD_LEN = 48;
  localparam int unsigned CRC7_W  = 7;

  // response type select, same encoding as the command register field
  typedef enum logic [1:0] {
    RSP_NONE       = 2'b00,
    RSP_LONG       = 2'b01, // 136 bit
    RSP_SHORT      = 2'b10, // 48 bit
    RSP_SHORT_BUSY = 2'b11  // 48 bit, then busy on dat0
  } rsp_type_e;

  typedef enum logic [2:0] {
    READY,
    WRITE_CMD,
    BUS_SWITCH,   // one turnaround cycle before listening
    READ_RSP,
    WAIT_BUSY,    // card holds dat0 low
    RSP_RECEIVED  // N_RC gap before the next command
  } cmd_seq_state_e;

  // one bit of crc7, g(x) = x^7 + x^3 + 1
  function automatic logic [6:0] crc7_step(
    input logic [6:0] crc,
    input logic       din
  );
    logic       fb;
    logic [6:0] nxt;
    fb  = din ^ crc[6];
    nxt = {crc[5:0], 1'b0};
    if (fb) begin
      nxt = nxt ^ 7'h09;
    end
    return nxt;
  endfunction

endpackage
